// ==== Makefile ====
SIM  := obj_dir/Vanchor_searcher_tb
SRCS := $(wildcard design/*.sv design/*.svh bench/*.sv)

.PHONY: all run clean

all: run

$(SIM): compile.f $(SRCS)
	verilator --binary --assert -Wno-fatal -f compile.f --top-module anchor_searcher_tb

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^Test OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/anchor_searcher_chk.sv ====
`timescale 1ns/1ns

module anchor_searcher_chk (
  input logic clk,
  input logic rst_n,
  input logic search_push_i,
  input logic search_full_i,
  input logic anchor_push_i,
  input logic anchor_full_i,
  input logic pop_i,
  input logic empty_i,
  input logic busy_i,
  input logic cen_i
);

  // without back-pressure a push into a full fifo drops an entry
  a_search_full: assert property (@(posedge clk) disable iff (!rst_n)
                                  !(search_push_i && search_full_i))
    else $error("push into the full search fifo");

  a_anchor_full: assert property (@(posedge clk) disable iff (!rst_n)
                                  !(anchor_push_i && anchor_full_i))
    else $error("push into the full anchor fifo");

  a_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) !(pop_i && empty_i))
    else $error("pop from the empty search fifo");

  a_idle_cen: assert property (@(posedge clk) disable iff (!rst_n) !busy_i |-> cen_i)
    else $error("memory enabled while the walker is idle");

endmodule

// walker writes both fifos and reads the search fifo
bind node_walker anchor_searcher_chk walker_chk (
  .clk (clk), .rst_n (rst_n),
  .search_push_i (search_wr.push), .search_full_i (search_wr.full),
  .anchor_push_i (anchor_wr.push), .anchor_full_i (anchor_wr.full),
  .pop_i (search_rd.pop), .empty_i (search_rd.empty),
  .busy_i (walking_q | walk_start_i), .cen_i (mem_cen_o)
);

// ==== bench/anchor_searcher_tb.sv ====
`timescale 1ns/1ns
`include "searcher_cfg.svh"

module anchor_searcher_tb import searcher_pkg::*; ();

  localparam int LIMIT_CYCLES = 20000;
  localparam int LEVEL_BASE [5] = '{0, 1, 9, 73, 585};
  localparam int unsigned PRIMES [5] = '{1, 2654435, 807545, 3867465, 2099719};

  logic      clk;
  logic      rst_n;
  logic      search_start_i;
  tree_idx_t tree_num_i;
  lod_mask_t lod_active_i;
  logic      search_done_o;
  logic      mem_cen_o;
  mem_addr_t mem_addr_o;
  mem_word_t mem_rdata_i;
  mem_word_t feature_o;
  logic      feature_valid_o;

  mem_word_t  mem [mem_addr_t];
  node_mask_t child_tab [int];
  node_mask_t self_tab [int];
  mem_word_t  expected_q [$];
  int         seed = 37396;
  int         error_count;
  int         checks_done;
  int         timeouts;
  int         word_count;
  int         done_count;

  anchor_searcher_top anchor_searcher_top_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .search_start_i  (search_start_i),
    .tree_num_i      (tree_num_i),
    .lod_active_i    (lod_active_i),
    .search_done_o   (search_done_o),
    .mem_cen_o       (mem_cen_o),
    .mem_addr_o      (mem_addr_o),
    .mem_rdata_i     (mem_rdata_i),
    .feature_o       (feature_o),
    .feature_valid_o (feature_valid_o)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // feature region pattern, every address bit matters
  function automatic mem_word_t fill_word(mem_addr_t a);
    return {a, ~a, a ^ 16'h5a5a, a[7:0], a[15:8]};
  endfunction

  function automatic mem_word_t read_word(mem_addr_t a);
    if (mem.exists(a)) return mem[a];
    if (a >= `SRCH_FEATURE_BASE) return fill_word(a);
    return '0;
  endfunction

  // one cycle read latency
  always @(posedge clk) begin
    if (!mem_cen_o) mem_rdata_i <= read_word(mem_addr_o);
  end

  function automatic int node_key(tree_idx_t t, int lv, int path);
    return int'(t) * 8192 + LEVEL_BASE[lv] + path;
  endfunction

  // path is octal, first offset most significant
  task automatic add_node(tree_idx_t t, int lv, int path, node_mask_t child, node_mask_t self);
    int        idx;
    mem_addr_t addr;
    mem_word_t word;
    idx  = LEVEL_BASE[lv] + path;
    addr = mem_addr_t'(int'(t) * `SRCH_TREE_STRIDE + idx / 4);
    word = read_word(addr);
    for (int k = 0; k < 8; k++) begin
      word[16 * (idx % 4) + 2 * k]     = child[k];
      word[16 * (idx % 4) + 2 * k + 1] = self[k];
    end
    mem[addr] = word;
    child_tab[node_key(t, lv, path)] = child;
    self_tab[node_key(t, lv, path)]  = self;
  endtask

  task automatic clear_trees();
    mem.delete();
    child_tab.delete();
    self_tab.delete();
  endtask

  task automatic build_random_tree(tree_idx_t t);
    int         open_lv [$];
    int         open_path [$];
    int         lv;
    int         path;
    int         nodes;
    node_mask_t child;
    node_mask_t self;
    nodes = 1;
    open_lv.push_back(0);
    open_path.push_back(0);
    while (open_lv.size() > 0) begin
      lv    = open_lv.pop_front();
      path  = open_path.pop_front();
      child = '0;
      if (lv < `SRCH_MAX_LEVEL) begin
        child = node_mask_t'($random(seed)) & node_mask_t'($random(seed));
        if (lv >= 2) child = child & node_mask_t'($random(seed));
      end
      // node cap keeps both fifos clear of full
      for (int k = 0; k < 8; k++) begin
        if (child[k] && nodes < 30) begin
          nodes++;
          open_lv.push_back(lv + 1);
          open_path.push_back(path * 8 + k);
        end else begin
          child[k] = 1'b0;
        end
      end
      self = node_mask_t'($random(seed)) & node_mask_t'($random(seed));
      add_node(t, lv, path, child, self);
    end
  endtask

  function automatic int unsigned feature_hash(int lv, int path, int k);
    int unsigned acc;
    int unsigned off;
    acc = 0;
    for (int i = 0; i <= lv; i++) begin
      off = (i == lv) ? k : (path >> (3 * (lv - 1 - i))) & 7;
      acc = acc ^ ((off + 1) * PRIMES[i]);
    end
    return acc % (1 << `SRCH_HASH_BITS);
  endfunction

  // breadth-first walk per tree, then the feature words of its anchors
  function automatic int expected_features(int trees, lod_mask_t lod);
    int          walk_lv [$];
    int          walk_path [$];
    int          hit_lv [$];
    int          hit_path [$];
    node_mask_t  hit_self [$];
    int          lv;
    int          path;
    int          key;
    int          anchors;
    node_mask_t  child;
    node_mask_t  self;
    int unsigned h;
    anchors = 0;
    expected_q.delete();
    for (int t = 0; t < trees; t++) begin
      walk_lv.push_back(0);
      walk_path.push_back(0);
      while (walk_lv.size() > 0) begin
        lv    = walk_lv.pop_front();
        path  = walk_path.pop_front();
        key   = node_key(tree_idx_t'(t), lv, path);
        child = child_tab.exists(key) ? child_tab[key] : '0;
        self  = self_tab.exists(key) ? self_tab[key] : '0;
        for (int k = 0; k < 8; k++) begin
          if (lv < `SRCH_MAX_LEVEL && child[k]) begin
            walk_lv.push_back(lv + 1);
            walk_path.push_back(path * 8 + k);
          end
        end
        if (lod[lv] && self != '0) begin
          hit_lv.push_back(lv);
          hit_path.push_back(path);
          hit_self.push_back(self);
        end
      end
      while (hit_lv.size() > 0) begin
        lv   = hit_lv.pop_front();
        path = hit_path.pop_front();
        self = hit_self.pop_front();
        for (int k = 0; k < 8; k++) begin
          if (self[k]) begin
            anchors++;
            h = feature_hash(lv, path, k);
            for (int j = 0; j < `SRCH_FEATURE_LEN; j++) begin
              expected_q.push_back(read_word(mem_addr_t'(`SRCH_FEATURE_BASE +
                                                         h * `SRCH_FEATURE_LEN + j)));
            end
          end
        end
      end
    end
    return anchors;
  endfunction

  task automatic check_word(string name, mem_word_t got, mem_word_t exp);
    checks_done++;
    if (got !== exp) begin
      error_count++;
      $display("ERROR %0t %s: got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_count(string name, mem_addr_t got, mem_addr_t exp);
    checks_done++;
    if (got !== exp) begin
      error_count++;
      $display("ERROR %0t %s: got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    checks_done++;
    if (got !== exp) begin
      error_count++;
      $display("ERROR %0t %s: got %b expected %b", $time, name, got, exp);
    end
  endtask

  // outputs sampled mid-cycle
  always @(negedge clk) begin
    if (rst_n && search_done_o) done_count++;
    if (rst_n && feature_valid_o) begin
      word_count++;
      if (expected_q.size() == 0) begin
        error_count++;
        $display("extra feature word %h at %0t with no word left to expect", feature_o, $time);
      end else begin
        check_word("feature_o", feature_o, expected_q.pop_front());
      end
    end
  end

  task automatic wait_search_done();
    int cycles;
    cycles = 0;
    while (done_count == 0 && cycles < LIMIT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    if (done_count == 0) begin
      timeouts++;
      $display("search_done_o did not pulse within %0d cycles", LIMIT_CYCLES);
    end
  endtask

  task automatic run_search(tree_idx_t trees, lod_mask_t lod);
    int anchors;
    if (timeouts != 0) return;
    anchors    = expected_features(int'(trees), lod);
    word_count = 0;
    done_count = 0;
    @(posedge clk);
    search_start_i <= 1'b1;
    tree_num_i     <= trees;
    lod_active_i   <= lod;
    @(posedge clk);
    search_start_i <= 1'b0;
    // config was latched, later changes must not leak in
    tree_num_i     <= trees + 1'b1;
    lod_active_i   <= ~lod;
    wait_search_done();
    for (int i = 0; i < 20; i++) @(posedge clk);
    if (timeouts == 0) begin
      check_count("search_done_o pulses", mem_addr_t'(done_count), 16'd1);
      check_count("anchor count", mem_addr_t'(word_count / `SRCH_FEATURE_LEN),
                  mem_addr_t'(anchors));
      check_count("words outstanding", mem_addr_t'(expected_q.size()), 16'd0);
    end
  endtask

  initial begin
    tree_idx_t trees;
    lod_mask_t lod;
    error_count    = 0;
    checks_done    = 0;
    timeouts       = 0;
    word_count     = 0;
    done_count     = 0;
    rst_n          = 1'b0;
    search_start_i = 1'b0;
    tree_num_i     = '0;
    lod_active_i   = '0;
    mem_rdata_i    = '0;

    for (int i = 0; i < 9; i++) @(posedge clk);
    @(negedge clk);
    check_bit("search_done_o", search_done_o, 1'b0);
    check_bit("feature_valid_o", feature_valid_o, 1'b0);
    check_bit("mem_cen_o", mem_cen_o, 1'b1);
    @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < 3; i++) begin
      @(negedge clk);
      check_bit("search_done_o", search_done_o, 1'b0);
      check_bit("feature_valid_o", feature_valid_o, 1'b0);
      check_bit("mem_cen_o", mem_cen_o, 1'b1);
    end

    // root only
    clear_trees();
    add_node(0, 0, 0, 8'h00, 8'b1010_0101);
    run_search(4'd1, 5'b11111);

    // three levels
    clear_trees();
    add_node(0, 0, 0, 8'h06, 8'h01);
    add_node(0, 1, 1, 8'h81, 8'h10);
    add_node(0, 1, 2, 8'h00, 8'h06);
    add_node(0, 2, 8, 8'h00, 8'h02);
    add_node(0, 2, 15, 8'h00, 8'h80);
    run_search(4'd1, 5'b11111);

    // levels 0 and 2 masked, level 3 still reached
    add_node(0, 2, 15, 8'h08, 8'h80);
    add_node(0, 3, 123, 8'h00, 8'h40);
    run_search(4'd1, 5'b01010);

    // three trees, tree 3 must stay untouched
    clear_trees();
    add_node(0, 0, 0, 8'h01, 8'h01);
    add_node(0, 1, 0, 8'h00, 8'h80);
    add_node(1, 0, 0, 8'h00, 8'h10);
    add_node(2, 0, 0, 8'h20, 8'h00);
    add_node(2, 1, 5, 8'h00, 8'h03);
    add_node(3, 0, 0, 8'h00, 8'hff);
    run_search(4'd3, 5'b11111);

    for (int run = 0; run < 4; run++) begin
      clear_trees();
      trees = tree_idx_t'(1 + {$random(seed)} % 3);
      lod   = lod_mask_t'($random(seed));
      for (int t = 0; t <= int'(trees); t++) build_random_tree(tree_idx_t'(t));
      run_search(trees, lod);
    end

    $display("checks: %0d, errors: %0d, timeouts: %0d", checks_done, error_count, timeouts);
    if (timeouts != 0 || error_count != 0) begin
      $display("Test FAILED");
    end else begin
      $display("Test OK");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+design
design/searcher_pkg.sv
design/fifo_if.sv
design/sync_fifo.sv
design/search_cfg_regs.sv
design/search_sequencer.sv
design/node_walker.sv
design/feature_reader.sv
design/anchor_searcher_top.sv
bench/anchor_searcher_chk.sv
bench/anchor_searcher_tb.sv

// ==== design/anchor_searcher_top.sv ====
`timescale 1ns/1ns
`include "searcher_cfg.svh"

module anchor_searcher_top import searcher_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      search_start_i,
  input  tree_idx_t tree_num_i,
  input  lod_mask_t lod_active_i,
  output logic      search_done_o,
  output logic      mem_cen_o,
  output mem_addr_t mem_addr_o,
  input  mem_word_t mem_rdata_i,
  output mem_word_t feature_o,
  output logic      feature_valid_o
);

  tree_idx_t tree_num;
  lod_mask_t lod_active;
  tree_idx_t tree_idx;
  logic      walk_start;
  logic      walk_done;
  logic      feature_start;
  logic      feature_done;
  logic      walk_cen;
  mem_addr_t walk_addr;
  logic      feat_cen;
  mem_addr_t feat_addr;

  fifo_if search_if ();
  fifo_if anchor_if ();

  search_cfg_regs search_cfg_regs_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_i      (search_start_i),
    .tree_num_i   (tree_num_i),
    .lod_active_i (lod_active_i),
    .tree_num_o   (tree_num),
    .lod_active_o (lod_active)
  );

  search_sequencer search_sequencer_inst (
    .clk (clk), .rst_n (rst_n), .search_start_i (search_start_i), .tree_num_i (tree_num),
    .walk_done_i (walk_done), .feature_done_i (feature_done), .walk_start_o (walk_start),
    .feature_start_o (feature_start), .tree_idx_o (tree_idx), .search_done_o (search_done_o),
    .walk_cen_i (walk_cen), .walk_addr_i (walk_addr), .feat_cen_i (feat_cen),
    .feat_addr_i (feat_addr), .mem_cen_o (mem_cen_o), .mem_addr_o (mem_addr_o)
  );

  node_walker node_walker_inst (
    .clk (clk), .rst_n (rst_n), .walk_start_i (walk_start), .tree_idx_i (tree_idx),
    .lod_active_i (lod_active), .mem_rdata_i (mem_rdata_i), .mem_cen_o (walk_cen),
    .mem_addr_o (walk_addr), .walk_done_o (walk_done),
    .search_rd (search_if), .search_wr (search_if), .anchor_wr (anchor_if)
  );

  feature_reader feature_reader_inst (
    .clk (clk), .rst_n (rst_n), .feature_start_i (feature_start), .mem_rdata_i (mem_rdata_i),
    .mem_cen_o (feat_cen), .mem_addr_o (feat_addr), .feature_o (feature_o),
    .feature_valid_o (feature_valid_o), .feature_done_o (feature_done), .anchor_rd (anchor_if)
  );

  sync_fifo #(.DEPTH(`SRCH_SEARCH_DEPTH)) search_fifo_inst (
    .clk (clk), .rst_n (rst_n), .f (search_if)
  );

  sync_fifo #(.DEPTH(`SRCH_ANCHOR_DEPTH)) anchor_fifo_inst (
    .clk (clk), .rst_n (rst_n), .f (anchor_if)
  );

endmodule

// ==== design/feature_reader.sv ====
`timescale 1ns/1ns
`include "searcher_cfg.svh"

module feature_reader import searcher_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      feature_start_i,
  input  mem_word_t mem_rdata_i,
  output logic      mem_cen_o,
  output mem_addr_t mem_addr_o,
  output mem_word_t feature_o,
  output logic      feature_valid_o,
  output logic      feature_done_o,
  fifo_if.reader    anchor_rd
);

  localparam int WW = $clog2(`SRCH_FEATURE_LEN);
  localparam logic [31:0] PRIMES [0:4] = '{32'd1, 32'd2654435, 32'd807545,
                                           32'd3867465, 32'd2099719};

  // prime xor over the used offsets
  function automatic hash_t anchor_hash(anchor_code_t code);
    level_t      lv;
    logic [31:0] acc;
    lv  = code[17:15];
    acc = '0;
    for (int i = 0; i <= `SRCH_MAX_LEVEL; i++) begin
      if (i <= lv) acc = acc ^ ((32'(code[14-3*i -: 3]) + 32'd1) * PRIMES[i]);
    end
    return acc[`SRCH_HASH_BITS-1:0];
  endfunction

  logic          active_q;
  logic          pop_pend_q;
  logic          done_q;
  logic          rd_valid_q;
  anchor_code_t  cur_code_q;
  node_mask_t    cur_mask_q;
  logic [WW-1:0] word_q;
  octant_t       k;
  anchor_code_t  anchor_code;
  hash_t         hash;
  logic          issue;
  logic          last_word;

  assign k = lowest_octant(cur_mask_q);

  // anchor is the node path followed by the self bit
  always_comb begin
    anchor_code = cur_code_q;
    anchor_code[14 - 3*cur_code_q[17:15] -: 3] = k;
  end

  assign hash      = anchor_hash(anchor_code);
  assign issue     = (cur_mask_q != '0);
  assign last_word = (word_q == WW'(`SRCH_FEATURE_LEN - 1));

  assign mem_cen_o  = ~issue;
  assign mem_addr_o = mem_addr_t'(`SRCH_FEATURE_BASE + 32'(hash) * `SRCH_FEATURE_LEN +
                                  32'(word_q));

  assign anchor_rd.pop = active_q && !anchor_rd.empty && !pop_pend_q && (cur_mask_q == '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active_q   <= 1'b0;
      pop_pend_q <= 1'b0;
      done_q     <= 1'b0;
      rd_valid_q <= 1'b0;
      cur_mask_q <= '0;
      word_q     <= '0;
    end else begin
      pop_pend_q <= anchor_rd.pop;
      rd_valid_q <= issue;
      done_q     <= 1'b0;
      if (feature_start_i) begin
        active_q <= 1'b1;
      end else if (active_q && anchor_rd.empty && !pop_pend_q && !issue && !rd_valid_q) begin
        active_q <= 1'b0;
        done_q   <= 1'b1;
      end
      if (pop_pend_q) begin
        cur_mask_q <= anchor_rd.rdata[7:0];
      end else if (issue) begin
        if (last_word) begin
          word_q     <= '0;
          cur_mask_q <= cur_mask_q & ~(node_mask_t'(1) << k);
        end else begin
          word_q <= word_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pop_pend_q) cur_code_q <= anchor_rd.rdata[25:8];
  end

  assign feature_valid_o = rd_valid_q;
  assign feature_o       = rd_valid_q ? mem_rdata_i : '0;
  assign feature_done_o  = done_q;

endmodule

// ==== design/fifo_if.sv ====
`timescale 1ns/1ns

interface fifo_if import searcher_pkg::*; ();

  logic        push;
  fifo_entry_t wdata;
  logic        pop;
  // valid the cycle after pop
  fifo_entry_t rdata;
  logic        empty;
  logic        full;

  modport writer (output push, output wdata, input full);

  modport reader (output pop, input rdata, input empty);

  modport storage (input push, input wdata, input pop,
                   output rdata, output empty, output full);

endinterface

// ==== design/node_walker.sv ====
`timescale 1ns/1ns
`include "searcher_cfg.svh"

module node_walker import searcher_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      walk_start_i,
  input  tree_idx_t tree_idx_i,
  input  lod_mask_t lod_active_i,
  input  mem_word_t mem_rdata_i,
  output logic      mem_cen_o,
  output mem_addr_t mem_addr_o,
  output logic      walk_done_o,
  fifo_if.reader    search_rd,
  fifo_if.writer    search_wr,
  fifo_if.writer    anchor_wr
);

  // dense layout, first node index of each level
  function automatic logic [12:0] level_base(level_t lv);
    case (lv)
      3'd0:    return 13'd0;
      3'd1:    return 13'd1;
      3'd2:    return 13'd9;
      3'd3:    return 13'd73;
      default: return 13'd585;
    endcase
  endfunction

  // path read as an octal number, first offset most significant
  function automatic logic [12:0] node_index(anchor_code_t code);
    level_t      lv;
    logic [12:0] acc;
    lv  = code[17:15];
    acc = '0;
    for (int i = 0; i < `SRCH_MAX_LEVEL; i++) begin
      if (i < lv) acc = {acc[9:0], code[14-3*i -: 3]};
    end
    return acc + level_base(lv);
  endfunction

  logic         walking_q;
  logic         pop_pend_q;
  logic         walk_done_q;
  anchor_code_t cur_code_q;
  node_mask_t   cur_mask_q;
  level_t       cur_lv;
  octant_t      next_k;

  logic         issue;
  anchor_code_t issue_code;
  logic [12:0]  issue_idx;

  // read pipeline, s1 waits for data, s2 pushes
  logic         s1_valid_q;
  anchor_code_t s1_code_q;
  logic [1:0]   s1_lane_q;
  logic [15:0]  lane_word;
  logic         s2_valid_q;
  anchor_code_t s2_code_q;
  node_mask_t   s2_child_q;
  node_mask_t   s2_self_q;
  level_t       s2_lv;
  logic         quiet;

  assign cur_lv = cur_code_q[17:15];
  assign next_k = lowest_octant(cur_mask_q);
  assign issue  = walk_start_i | (cur_mask_q != '0);

  // child of the current node, or the root on start
  always_comb begin
    issue_code = cur_code_q;
    issue_code[17:15] = cur_lv + 3'd1;
    issue_code[14 - 3*cur_lv -: 3] = next_k;
    if (walk_start_i) issue_code = '0;
  end

  assign issue_idx  = node_index(issue_code);
  assign mem_cen_o  = ~issue;
  assign mem_addr_o = mem_addr_t'(32'(tree_idx_i) * `SRCH_TREE_STRIDE + 32'(issue_idx[12:2]));

  assign search_rd.pop = walking_q && !search_rd.empty && !pop_pend_q && (cur_mask_q == '0);

  assign quiet = search_rd.empty && !pop_pend_q && (cur_mask_q == '0) &&
                 !s1_valid_q && !s2_valid_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      walking_q   <= 1'b0;
      pop_pend_q  <= 1'b0;
      walk_done_q <= 1'b0;
      cur_mask_q  <= '0;
      s1_valid_q  <= 1'b0;
      s2_valid_q  <= 1'b0;
    end else begin
      pop_pend_q  <= search_rd.pop;
      s1_valid_q  <= issue;
      s2_valid_q  <= s1_valid_q;
      walk_done_q <= 1'b0;
      if (walk_start_i) begin
        walking_q <= 1'b1;
      end else if (walking_q && quiet) begin
        walking_q   <= 1'b0;
        walk_done_q <= 1'b1;
      end
      if (pop_pend_q) begin
        cur_mask_q <= search_rd.rdata[7:0];
      end else if (cur_mask_q != '0) begin
        cur_mask_q <= cur_mask_q & ~(node_mask_t'(1) << next_k);
      end
    end
  end

  assign lane_word = mem_rdata_i[16*s1_lane_q +: 16];

  always_ff @(posedge clk) begin
    if (pop_pend_q) cur_code_q <= search_rd.rdata[25:8];
    s1_code_q <= issue_code;
    s1_lane_q <= issue_idx[1:0];
    s2_code_q <= s1_code_q;
    // even bits are children, odd bits are self
    for (int k = 0; k < 8; k++) begin
      s2_child_q[k] <= lane_word[2*k];
      s2_self_q[k]  <= lane_word[2*k+1];
    end
  end

  assign s2_lv = s2_code_q[17:15];

  assign search_wr.push  = s2_valid_q && (s2_child_q != '0) && (s2_lv < `SRCH_MAX_LEVEL);
  assign search_wr.wdata = {s2_code_q, s2_child_q};
  assign anchor_wr.push  = s2_valid_q && lod_active_i[s2_lv] && (s2_self_q != '0);
  assign anchor_wr.wdata = {s2_code_q, s2_self_q};

  assign walk_done_o = walk_done_q;

endmodule

// ==== design/search_cfg_regs.sv ====
`timescale 1ns/1ns

module search_cfg_regs import searcher_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      start_i,
  input  tree_idx_t tree_num_i,
  input  lod_mask_t lod_active_i,
  output tree_idx_t tree_num_o,
  output lod_mask_t lod_active_o
);

  // captured once per run so the inputs may change afterwards
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tree_num_o   <= '0;
      lod_active_o <= '0;
    end else if (start_i) begin
      tree_num_o   <= tree_num_i;
      lod_active_o <= lod_active_i;
    end
  end

endmodule

// ==== design/search_sequencer.sv ====
`timescale 1ns/1ns

module search_sequencer import searcher_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      search_start_i,
  input  tree_idx_t tree_num_i,
  input  logic      walk_done_i,
  input  logic      feature_done_i,
  output logic      walk_start_o,
  output logic      feature_start_o,
  output tree_idx_t tree_idx_o,
  output logic      search_done_o,
  input  logic      walk_cen_i,
  input  mem_addr_t walk_addr_i,
  input  logic      feat_cen_i,
  input  mem_addr_t feat_addr_i,
  output logic      mem_cen_o,
  output mem_addr_t mem_addr_o
);

  seq_state_t state_q;
  logic       last_tree;

  // a tree count of zero still runs tree 0
  assign last_tree = ({1'b0, tree_idx_o} + 5'd1) >= {1'b0, tree_num_i};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q         <= IDLE;
      tree_idx_o      <= '0;
      walk_start_o    <= 1'b0;
      feature_start_o <= 1'b0;
      search_done_o   <= 1'b0;
    end else begin
      walk_start_o    <= 1'b0;
      feature_start_o <= 1'b0;
      search_done_o   <= 1'b0;
      case (state_q)
        IDLE: begin
          if (search_start_i) begin
            tree_idx_o   <= '0;
            walk_start_o <= 1'b1;
            state_q      <= WALK;
          end
        end
        WALK: begin
          if (walk_done_i) begin
            feature_start_o <= 1'b1;
            state_q         <= FEATURE;
          end
        end
        FEATURE: begin
          if (feature_done_i) state_q <= NEXT;
        end
        NEXT: begin
          if (last_tree) begin
            search_done_o <= 1'b1;
            state_q       <= IDLE;
          end else begin
            tree_idx_o   <= tree_idx_o + 1'b1;
            walk_start_o <= 1'b1;
            state_q      <= WALK;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // memory port goes to whichever client owns the phase
  always_comb begin
    case (state_q)
      WALK: begin
        mem_cen_o  = walk_cen_i;
        mem_addr_o = walk_addr_i;
      end
      FEATURE: begin
        mem_cen_o  = feat_cen_i;
        mem_addr_o = feat_addr_i;
      end
      default: begin
        mem_cen_o  = 1'b1;
        mem_addr_o = '0;
      end
    endcase
  end

endmodule

// ==== design/searcher_cfg.svh ====
`ifndef SEARCHER_CFG_SVH
`define SEARCHER_CFG_SVH

// deepest octree level, root is level 0
`define SRCH_MAX_LEVEL     4
// words per feature record
`define SRCH_FEATURE_LEN   9
// memory words reserved per tree
`define SRCH_TREE_STRIDE   2048
`define SRCH_FEATURE_BASE  32768
`define SRCH_HASH_BITS     11
// fifo depths
`define SRCH_SEARCH_DEPTH  32
`define SRCH_ANCHOR_DEPTH  64

`endif

// ==== design/searcher_pkg.sv ====
`include "searcher_cfg.svh"

package searcher_pkg;

  typedef logic [15:0] mem_addr_t;
  typedef logic [63:0] mem_word_t;
  typedef logic [2:0]  level_t;
  typedef logic [2:0]  octant_t;
  typedef logic [7:0]  node_mask_t;
  // level in [17:15], offset 0 in [14:12] down to offset 4 in [2:0]
  typedef logic [17:0] anchor_code_t;
  // code above mask
  typedef logic [25:0] fifo_entry_t;
  typedef logic [3:0]  tree_idx_t;
  typedef logic [4:0]  lod_mask_t;
  typedef logic [`SRCH_HASH_BITS-1:0] hash_t;

  typedef enum logic [1:0] {IDLE, WALK, FEATURE, NEXT} seq_state_t;

  // index of the lowest set bit, zero for an empty mask
  function automatic octant_t lowest_octant(node_mask_t mask);
    octant_t k;
    k = '0;
    for (int i = 7; i >= 0; i--) begin
      if (mask[i]) k = octant_t'(i);
    end
    return k;
  endfunction

endpackage

// ==== design/sync_fifo.sv ====
`timescale 1ns/1ns

module sync_fifo import searcher_pkg::*; #(
  parameter int DEPTH = 32
) (
  input logic     clk,
  input logic     rst_n,
  fifo_if.storage f
);

  localparam int PW = $clog2(DEPTH);

  fifo_entry_t   mem [DEPTH];
  logic [PW-1:0] wr_ptr_q;
  logic [PW-1:0] rd_ptr_q;
  logic [PW:0]   count_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (f.push) begin
        wr_ptr_q <= (wr_ptr_q == PW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (f.pop) begin
        rd_ptr_q <= (rd_ptr_q == PW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({f.push, f.pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (f.push) mem[wr_ptr_q] <= f.wdata;
    if (f.pop) f.rdata <= mem[rd_ptr_q];
  end

  assign f.empty = (count_q == '0);
  assign f.full  = (count_q == (PW + 1)'(DEPTH));

endmodule
